/* src/uart_pkg.sv */
package uart_pkg;

   // One data byte as it travels on the serial line
   typedef logic [7:0] uart_byte_t;

   // Receive FIFO payload
   // frame_err is set when the stop bit sampled low
   typedef struct packed {
      uart_byte_t data;
      logic       frame_err;
   } rx_frame_t;

   // Receiver FSM
   // DETECT filters the start bit
   // PENDING waits out the rest of a bit period
   // SHIFT is the one-cycle mid-bit sample
   typedef enum logic [1:0] {
      RX_DETECT  = 2'd0,
      RX_PENDING = 2'd1,
      RX_SHIFT   = 2'd2
   } rx_state_t;

endpackage

/* src/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic [7:0]
) (
   input  logic     baud_clk,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] PTR_ONE = (AW + 1)'(1);

   payload_t    mem [DEPTH];
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic [AW:0] rd_next;
   logic        push;
   logic        pop;

   // Full when wrap bits differ and addresses match
   assign in_ready = !((wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]));
   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // Head position once this cycle's pop is taken
   assign rd_next = pop ? rd_ptr + PTR_ONE : rd_ptr;

   // Storage written at the tail
   always_ff @(posedge baud_clk) begin
      if (push) begin
         mem[wr_ptr[AW-1:0]] <= in_data;
      end
   end

   always_ff @(posedge baud_clk) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (push) begin
         wr_ptr <= wr_ptr + PTR_ONE;
      end
   end

   // Read side
   // out_valid mirrors the occupancy seen before this edge
   // so a new entry shows up one cycle after its write
   always_ff @(posedge baud_clk) begin
      if (rst) begin
         rd_ptr    <= '0;
         out_valid <= 1'b0;
      end else begin
         rd_ptr    <= rd_next;
         out_valid <= (wr_ptr != rd_next);
      end
   end

   // Registered copy of the head entry
   // Stays put during a stall since the head slot is never rewritten
   always_ff @(posedge baud_clk) begin
      out_data <= mem[rd_next[AW-1:0]];
   end

   // A full buffer must be offering its head
   a_full_has_head: assert property (@(posedge baud_clk) disable iff (rst)
      !in_ready |-> out_valid);

endmodule

/* src/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
   parameter int OVERSAMPLE = 8
) (
   input  logic                baud_clk,
   input  logic                rst,
   input  logic                rxd,
   output uart_pkg::rx_frame_t frame,
   output logic                frame_valid
);

   import uart_pkg::*;

   localparam int CW = $clog2(OVERSAMPLE);
   // Last count of the start filter
   localparam logic [CW-1:0] HALF_LAST = CW'(OVERSAMPLE / 2 - 1);
   // Last count before the sample cycle
   localparam logic [CW-1:0] PEND_LAST = CW'(OVERSAMPLE - 2);
   localparam logic [CW-1:0] CNT_ONE   = CW'(1);

   logic [1:0]    sync_q;
   logic          rxd_s;
   rx_state_t     state;
   logic [CW-1:0] smpl_cnt;
   logic [3:0]    bit_cnt;
   logic          armed;
   uart_byte_t    data_q;

   // Two-flop synchronizer
   // Resets to the idle level so no false start is seen
   always_ff @(posedge baud_clk) begin
      if (rst) begin
         sync_q <= 2'b11;
      end else begin
         sync_q <= {sync_q[0], rxd};
      end
   end

   assign rxd_s = sync_q[1];

   // Receive FSM
   always_ff @(posedge baud_clk) begin
      if (rst) begin
         state       <= RX_DETECT;
         smpl_cnt    <= '0;
         bit_cnt     <= '0;
         armed       <= 1'b0;
         frame_valid <= 1'b0;
      end else begin
         frame_valid <= 1'b0;
         case (state)
            RX_DETECT: begin
               if (rxd_s) begin
                  // High line arms the start detector
                  armed    <= 1'b1;
                  smpl_cnt <= '0;
               end else if (!armed) begin
                  // Still low after a bad stop bit
                  smpl_cnt <= '0;
               end else if (smpl_cnt == HALF_LAST) begin
                  // Start held for half a bit
                  // Now close to its middle
                  smpl_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= RX_PENDING;
               end else begin
                  smpl_cnt <= smpl_cnt + CNT_ONE;
               end
            end
            RX_PENDING: begin
               // OVERSAMPLE-1 cycles here plus one in SHIFT
               smpl_cnt <= smpl_cnt + CNT_ONE;
               if (smpl_cnt == PEND_LAST) begin
                  state <= RX_SHIFT;
               end
            end
            RX_SHIFT: begin
               smpl_cnt <= '0;
               if (bit_cnt == 4'd8) begin
                  // Mid stop bit
                  // Emit frame and wait for an idle line
                  frame_valid <= 1'b1;
                  armed       <= 1'b0;
                  state       <= RX_DETECT;
               end else begin
                  bit_cnt <= bit_cnt + 4'd1;
                  state   <= RX_PENDING;
               end
            end
            default: begin
               state <= RX_DETECT;
            end
         endcase
      end
   end

   // Data path
   // Bits arrive LSB first and shift in from the top
   always_ff @(posedge baud_clk) begin
      if (state == RX_SHIFT) begin
         if (bit_cnt == 4'd8) begin
            frame <= '{data: data_q, frame_err: !rxd_s};
         end else begin
            data_q <= {rxd_s, data_q[7:1]};
         end
      end
   end

   // One frame per stop bit
   a_valid_pulse: assert property (@(posedge baud_clk) disable iff (rst)
      frame_valid |=> !frame_valid);

   a_state_legal: assert property (@(posedge baud_clk) disable iff (rst)
      state inside {RX_DETECT, RX_PENDING, RX_SHIFT});

endmodule

/* src/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
   parameter int OVERSAMPLE = 8
) (
   input  logic                 baud_clk,
   input  logic                 rst,
   input  uart_pkg::uart_byte_t data,
   input  logic                 valid,
   output logic                 ready,
   output logic                 txd
);

   localparam int CW = $clog2(OVERSAMPLE);
   // End of a bit period
   localparam logic [CW-1:0] CYC_LAST   = CW'(OVERSAMPLE - 1);
   // Stop bit releases the shifter one cycle ahead
   localparam logic [CW-1:0] STOP_EARLY = CW'(OVERSAMPLE - 2);
   localparam logic [CW-1:0] CNT_ONE    = CW'(1);

   logic [9:0]    shreg;
   logic [CW-1:0] cyc_cnt;
   logic [3:0]    bit_cnt;
   logic          busy;

   assign ready = !busy;

   // Line driven straight from the shifter flop
   assign txd = shreg[0];

   always_ff @(posedge baud_clk) begin
      if (rst) begin
         shreg   <= '1;
         cyc_cnt <= '0;
         bit_cnt <= '0;
         busy    <= 1'b0;
      end else if (valid && ready) begin
         // Stop, data, start
         shreg   <= {1'b1, data, 1'b0};
         cyc_cnt <= '0;
         bit_cnt <= '0;
         busy    <= 1'b1;
      end else if (busy) begin
         cyc_cnt <= cyc_cnt + CNT_ONE;
         if ((bit_cnt == 4'd9) && (cyc_cnt == STOP_EARLY)) begin
            // Stop bit stays on the line one more cycle
            // so a byte taken now starts right after it
            busy <= 1'b0;
         end else if (cyc_cnt == CYC_LAST) begin
            // Next bit
            // Ones fill in behind it
            shreg   <= {1'b1, shreg[9:1]};
            bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   // Line idles high
   a_idle_high: assert property (@(posedge baud_clk) disable iff (rst)
      !busy |-> txd);

endmodule

/* src/debug_console.sv */
`timescale 1ns/10ps

module debug_console #(
   parameter int OVERSAMPLE = 8,
   parameter int TX_DEPTH   = 4,
   parameter int RX_DEPTH   = 4
) (
   input  logic                 baud_clk,
   input  logic                 rst,
   input  logic                 rxd,
   output logic                 txd,
   input  uart_pkg::uart_byte_t tx_data,
   input  logic                 tx_valid,
   output logic                 tx_ready,
   output uart_pkg::rx_frame_t  rx_frame,
   output logic                 rx_valid,
   input  logic                 rx_ready,
   output logic                 overrun
);

   import uart_pkg::*;

   // Transmit FIFO to serializer
   uart_byte_t tx_q_data;
   logic       tx_q_valid;
   logic       tx_q_ready;

   // Receiver to receive FIFO
   rx_frame_t  rx_in_frame;
   logic       rx_in_valid;
   logic       rx_in_ready;

   sync_fifo #(
      .DEPTH     (TX_DEPTH),
      .payload_t (uart_byte_t)
   ) u_tx_fifo (
      .baud_clk  (baud_clk),
      .rst       (rst),
      .in_data   (tx_data),
      .in_valid  (tx_valid),
      .in_ready  (tx_ready),
      .out_data  (tx_q_data),
      .out_valid (tx_q_valid),
      .out_ready (tx_q_ready)
   );

   uart_tx #(
      .OVERSAMPLE (OVERSAMPLE)
   ) u_tx (
      .baud_clk (baud_clk),
      .rst      (rst),
      .data     (tx_q_data),
      .valid    (tx_q_valid),
      .ready    (tx_q_ready),
      .txd      (txd)
   );

   uart_rx #(
      .OVERSAMPLE (OVERSAMPLE)
   ) u_rx (
      .baud_clk    (baud_clk),
      .rst         (rst),
      .rxd         (rxd),
      .frame       (rx_in_frame),
      .frame_valid (rx_in_valid)
   );

   // Receiver cannot stall
   // A frame meeting a full FIFO is simply not written
   sync_fifo #(
      .DEPTH     (RX_DEPTH),
      .payload_t (rx_frame_t)
   ) u_rx_fifo (
      .baud_clk  (baud_clk),
      .rst       (rst),
      .in_data   (rx_in_frame),
      .in_valid  (rx_in_valid),
      .in_ready  (rx_in_ready),
      .out_data  (rx_frame),
      .out_valid (rx_valid),
      .out_ready (rx_ready)
   );

   // Sticky overrun, cleared by rst only
   always_ff @(posedge baud_clk) begin
      if (rst) begin
         overrun <= 1'b0;
      end else if (rx_in_valid && !rx_in_ready) begin
         overrun <= 1'b1;
      end
   end

   // Frames are lost only while the host has one waiting
   a_drop_when_pending: assert property (@(posedge baud_clk) disable iff (rst)
      rx_in_valid && !rx_in_ready |-> rx_valid);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
   output logic baud_clk,
   output logic rst
);

   // 4 ns period
   localparam int HALF_NS    = 2;
   localparam int RST_CYCLES = 5;

   initial begin
      baud_clk = 1'b0;
      forever begin
         #HALF_NS baud_clk = ~baud_clk;
      end
   end

   // Released just after an edge, like every other input
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge baud_clk);
      #1;
      rst = 1'b0;
   end

endmodule

/* test/tb_debug_console.sv */
`timescale 1ns/10ps

module tb_debug_console;

   import uart_pkg::*;

   // Must match the DUT defaults
   localparam int OVERSAMPLE = 8;
   localparam int RX_DEPTH   = 4;
   localparam int N_LOOP     = 32;
   localparam int N_BURST    = 8;
   // Frames over all tests
   localparam int N_FRAMES    = N_LOOP + 2 + 1 + RX_DEPTH + 2 + N_BURST;
   // Ten bits per frame, plus a quarter on top
   localparam int CYCLE_LIMIT = N_FRAMES * 10 * OVERSAMPLE * 5 / 4;

   logic        baud_clk;
   logic        rst;
   logic        rxd;
   logic        txd;
   uart_byte_t  tx_data;
   logic        tx_valid;
   logic        tx_ready;
   rx_frame_t   rx_frame;
   logic        rx_valid;
   logic        rx_ready;
   logic        overrun;

   // Line select, 0 loopback from txd, 1 bit driver
   logic        line_sel;
   logic        drv_rxd;
   logic [15:0] lfsr;
   // Phase flags owned by the stimulus
   logic        quiet;
   logic        ovr_allowed;
   logic        ovr_required;
   logic        burst_phase;

   // Expected frames, pushed by the stimulus only
   rx_frame_t   exp_q [$];
   // Monitor side of the queue
   int          exp_rd    = 0;
   int          exp_cnt   = 0;
   rx_frame_t   exp_head  = '0;
   logic        saw_full  = 1'b0;
   int          cycle_cnt = 0;

   tb_clock u_clock (
      .baud_clk (baud_clk),
      .rst      (rst)
   );

   debug_console u_debug_console (
      .baud_clk (baud_clk),
      .rst      (rst),
      .rxd      (rxd),
      .txd      (txd),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .rx_frame (rx_frame),
      .rx_valid (rx_valid),
      .rx_ready (rx_ready),
      .overrun  (overrun)
   );

   assign rxd = line_sel ? drv_rxd : txd;

   task automatic fail_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at first failure");
   endtask

   // Inputs change 1 ns after the edge
   task automatic next_cycle();
      @(posedge baud_clk);
      #1;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[6:0], lfsr[0]};
      end
   endtask

   task automatic expect_frame(input uart_byte_t data, input logic err);
      rx_frame_t f;
      f.data      = data;
      f.frame_err = err;
      exp_q.push_back(f);
   endtask

   // Host push, held until the FIFO takes it
   task automatic push_byte(input uart_byte_t b);
      tx_data  = b;
      tx_valid = 1'b1;
      quiet    = 1'b0;
      while (!tx_ready) begin
         next_cycle();
      end
      expect_frame(b, 1'b0);
      next_cycle();
      tx_valid = 1'b0;
   endtask

   // Start, data LSB first, chosen stop level, then idle high
   task automatic send_serial(input uart_byte_t b, input logic stop);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         drv_rxd = bits[i];
         wait_cycles(OVERSAMPLE);
      end
      drv_rxd = 1'b1;
      wait_cycles(2 * OVERSAMPLE);
   endtask

   task automatic send_glitch(input int len);
      drv_rxd = 1'b0;
      wait_cycles(len);
      drv_rxd = 1'b1;
      wait_cycles(2 * OVERSAMPLE);
   endtask

   task automatic wait_drained();
      while (exp_cnt != 0) begin
         next_cycle();
      end
   endtask

   // Queue monitor, back-pressure seen and run length
   always @(posedge baud_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (!rst && burst_phase && !tx_ready) begin
         saw_full = 1'b1;
      end
      if (!rst && rx_valid && rx_ready && (exp_rd < exp_q.size())) begin
         exp_rd = exp_rd + 1;
      end
      exp_cnt = exp_q.size() - exp_rd;
      if (exp_cnt > 0) begin
         exp_head = exp_q[exp_rd];
      end
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Run timed out after %0d cycles", cycle_cnt);
         fail_run();
      end
   end

   // Nothing may arrive that was not sent
   a_frame_expected: assert property (@(posedge baud_clk) disable iff (rst)
      rx_valid && rx_ready |-> exp_cnt > 0)
      else begin
         $display("A frame arrived that was never sent, rx_frame %h", $sampled(rx_frame));
         fail_run();
      end

   // In order, with the right error flag
   a_frame_value: assert property (@(posedge baud_clk) disable iff (rst)
      rx_valid && rx_ready && exp_cnt > 0 |-> rx_frame == exp_head)
      else begin
         $display("ERROR rx_frame got %h expected %h",
                  $sampled(rx_frame), $sampled(exp_head));
         fail_run();
      end

   // Idle console until the first push
   a_quiet_start: assert property (@(posedge baud_clk) disable iff (rst)
      quiet |-> txd && !rx_valid && !overrun)
      else begin
         $display("ERROR txd %h rx_valid %h overrun %h expected 1 0 0",
                  $sampled(txd), $sampled(rx_valid), $sampled(overrun));
         fail_run();
      end

   a_no_overrun: assert property (@(posedge baud_clk) disable iff (rst)
      !ovr_allowed |-> !overrun)
      else begin
         $display("ERROR overrun got %h expected 0", $sampled(overrun));
         fail_run();
      end

   // Sticky once frames were dropped
   a_overrun_set: assert property (@(posedge baud_clk) disable iff (rst)
      ovr_required |-> overrun)
      else begin
         $display("ERROR overrun got %h expected 1", $sampled(overrun));
         fail_run();
      end

   initial begin
      uart_byte_t b;
      logic [7:0] gap;
      tx_data      = '0;
      tx_valid     = 1'b0;
      rx_ready     = 1'b1;
      line_sel     = 1'b0;
      drv_rxd      = 1'b1;
      lfsr         = 16'd18175;
      quiet        = 1'b1;
      ovr_allowed  = 1'b0;
      ovr_required = 1'b0;
      burst_phase  = 1'b0;
      @(negedge rst);
      wait_cycles(4 * OVERSAMPLE);

      // Loopback with random gaps between pushes
      for (int i = 0; i < N_LOOP; i++) begin
         draw_bits(8, b);
         draw_bits(4, gap);
         wait_cycles(int'(gap));
         push_byte(b);
      end
      wait_drained();

      // Low stop bit, then a clean frame
      line_sel = 1'b1;
      draw_bits(8, b);
      expect_frame(b, 1'b1);
      send_serial(b, 1'b0);
      draw_bits(8, b);
      expect_frame(b, 1'b0);
      send_serial(b, 1'b1);
      wait_drained();

      // Glitch too short for a start bit
      send_glitch(OVERSAMPLE / 2 - 1);
      draw_bits(8, b);
      expect_frame(b, 1'b0);
      send_serial(b, 1'b1);
      wait_drained();

      // Host stalled, last two frames dropped
      rx_ready    = 1'b0;
      ovr_allowed = 1'b1;
      for (int i = 0; i < RX_DEPTH + 2; i++) begin
         draw_bits(8, b);
         if (i < RX_DEPTH) begin
            expect_frame(b, 1'b0);
         end
         send_serial(b, 1'b1);
      end
      ovr_required = 1'b1;
      rx_ready     = 1'b1;
      wait_drained();
      wait_cycles(2 * OVERSAMPLE);
      assert (!rx_valid)
         else begin
            $display("ERROR rx_valid got %h expected 0 after drain", rx_valid);
            fail_run();
         end

      // Back-to-back pushes outrun the line
      line_sel    = 1'b0;
      burst_phase = 1'b1;
      for (int i = 0; i < N_BURST; i++) begin
         draw_bits(8, b);
         push_byte(b);
      end
      wait_drained();
      assert (saw_full)
         else begin
            $display("Transmit FIFO never held tx_ready low during the burst");
            fail_run();
         end

      wait_cycles(4);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* debug_console.f */
src/uart_pkg.sv
src/sync_fifo.sv
src/uart_rx.sv
src/uart_tx.sv
src/debug_console.sv
test/tb_clock.sv
test/tb_debug_console.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug console testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_debug_console \
   -f debug_console.f -o tb_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation passed"
exit 0
